// ==== issue_pkg.sv ====
package issue_pkg;

    localparam int xlen           = 64;
    localparam int reg_addr_w     = 5;
    localparam int lsp_offset_w   = 12;
    localparam int op_w           = 4;
    localparam int num_read_ports = 4;

    typedef logic [xlen-1:0]       xlen_t;
    typedef logic [reg_addr_w-1:0] reg_addr_t;

    // Instruction class from decode
    typedef enum logic [2:0] {
        op_int    = 3'd0,
        op_branch = 3'd1,
        op_load   = 3'd2,
        op_store  = 3'd3,
        op_muldiv = 3'd4,
        op_trap   = 3'd5,
        op_fence  = 3'd6
    } op_type_e;

    typedef enum logic [1:0] {
        opr1_rs1  = 2'd0,
        opr1_pc   = 2'd1,
        opr1_zero = 2'd2,
        opr1_zimm = 2'd3
    } opr1_sel_e;

    typedef enum logic [1:0] {
        opr2_rs2  = 2'd0,
        opr2_imm  = 2'd1,
        opr2_four = 2'd2
    } opr2_sel_e;

    typedef struct packed {
        xlen_t           pc;
        logic [op_w-1:0] op;
        logic            option;
        logic            truncate;
        logic            mem_sign;
        logic [1:0]      mem_width;
        op_type_e        op_type;
        opr1_sel_e       opr1_sel;
        opr2_sel_e       opr2_sel;
        xlen_t           imm;
        logic            wb_en;
        reg_addr_t       rs1;
        reg_addr_t       rs2;
        reg_addr_t       rd;
    } dec_bundle_t;

    typedef struct packed {
        xlen_t           pc;
        reg_addr_t       dst;
        logic            wb_en;
        logic [op_w-1:0] op;
        logic            option;
        logic            truncate;
        xlen_t           operand1;
        xlen_t           operand2;
    } ip_req_t;

    typedef struct packed {
        xlen_t                   pc;
        reg_addr_t               dst;
        logic                    wb_en;
        xlen_t                   base;
        logic [lsp_offset_w-1:0] offset;
        xlen_t                   source;
        logic                    mem_sign;
        logic [1:0]              mem_width;
    } lsp_req_t;

    typedef struct packed {
        logic      valid;
        logic      wb_en;
        reg_addr_t dst;
        xlen_t     result;
    } wb_fwd_t;

    // State of one issued request while it sits in an output register
    typedef struct packed {
        logic      valid;
        logic      ready;
        logic      wb_en;
        reg_addr_t dst;
    } ex_track_t;

    typedef struct packed {
        logic issue;
        logic from_slot1;
    } issue_sel_t;

    function automatic logic ex_writes(ex_track_t t, reg_addr_t r);
        return t.valid && t.wb_en && (t.dst == r);
    endfunction

    function automatic logic wb_writes(wb_fwd_t w, reg_addr_t r);
        return w.valid && w.wb_en && (w.dst == r);
    endfunction

endpackage

// ==== operand_bypass.sv ====
module operand_bypass import issue_pkg::*; (
    input  reg_addr_t src,
    input  xlen_t     rf_data,
    input  ex_track_t ip0_ex,
    input  ex_track_t ip1_ex,
    input  ex_track_t lsp_ag,
    input  xlen_t     ip0_fwd,
    input  xlen_t     ip1_fwd,
    input  wb_fwd_t   ip0_wb,
    input  wb_fwd_t   ip1_wb,
    input  wb_fwd_t   lsp_wb,
    input  logic      lsp_mem_wb_en,
    input  reg_addr_t lsp_mem_dst,
    output xlen_t     value,
    output logic      ready
);

    // Points run from late to early, so the youngest producer wins
    always_comb begin
        value = rf_data;
        ready = 1'b1;
        if (wb_writes(ip0_wb, src)) begin
            value = ip0_wb.result;
            ready = 1'b1;
        end
        if (wb_writes(ip1_wb, src)) begin
            value = ip1_wb.result;
            ready = 1'b1;
        end
        // Execute result, only once the pipe has taken the request
        if (ex_writes(ip0_ex, src) && ip0_ex.ready) begin
            value = ip0_fwd;
            ready = 1'b1;
        end
        if (ex_writes(ip1_ex, src) && ip1_ex.ready) begin
            value = ip1_fwd;
            ready = 1'b1;
        end
        // Request still waiting in the output register
        if (ex_writes(ip0_ex, src) && !ip0_ex.ready) begin
            ready = 1'b0;
        end
        if (ex_writes(ip1_ex, src) && !ip1_ex.ready) begin
            ready = 1'b0;
        end
        if (wb_writes(lsp_wb, src)) begin
            value = lsp_wb.result;
            ready = 1'b1;
        end
        // Load data not back yet
        if (lsp_mem_wb_en && (lsp_mem_dst == src)) begin
            ready = 1'b0;
        end
        if (ex_writes(lsp_ag, src)) begin
            ready = 1'b0;
        end
        // x0 reads zero whatever any pipe claims to write
        if (src == '0) begin
            value = '0;
            ready = 1'b1;
        end
    end

endmodule

// ==== operand_select.sv ====
module operand_select import issue_pkg::*; (
    input  dec_bundle_t inst,
    input  xlen_t       rs1_data,
    input  xlen_t       rs2_data,
    input  ex_track_t   ip0_ex,
    input  ex_track_t   ip1_ex,
    input  ex_track_t   lsp_ag,
    input  xlen_t       ip0_fwd,
    input  xlen_t       ip1_fwd,
    input  wb_fwd_t     ip0_wb,
    input  wb_fwd_t     ip1_wb,
    input  wb_fwd_t     lsp_wb,
    input  logic        lsp_mem_wb_en,
    input  reg_addr_t   lsp_mem_dst,
    output xlen_t       operand1,
    output xlen_t       operand2,
    output logic        ready
);

    xlen_t rs1_value;
    xlen_t rs2_value;
    logic  rs1_ready;
    logic  rs2_ready;

    operand_bypass i_rs1_bypass (
        .src(inst.rs1), .rf_data(rs1_data),
        .ip0_ex(ip0_ex), .ip1_ex(ip1_ex), .lsp_ag(lsp_ag),
        .ip0_fwd(ip0_fwd), .ip1_fwd(ip1_fwd),
        .ip0_wb(ip0_wb), .ip1_wb(ip1_wb), .lsp_wb(lsp_wb),
        .lsp_mem_wb_en(lsp_mem_wb_en), .lsp_mem_dst(lsp_mem_dst),
        .value(rs1_value), .ready(rs1_ready)
    );

    operand_bypass i_rs2_bypass (
        .src(inst.rs2), .rf_data(rs2_data),
        .ip0_ex(ip0_ex), .ip1_ex(ip1_ex), .lsp_ag(lsp_ag),
        .ip0_fwd(ip0_fwd), .ip1_fwd(ip1_fwd),
        .ip0_wb(ip0_wb), .ip1_wb(ip1_wb), .lsp_wb(lsp_wb),
        .lsp_mem_wb_en(lsp_mem_wb_en), .lsp_mem_dst(lsp_mem_dst),
        .value(rs2_value), .ready(rs2_ready)
    );

    always_comb begin
        case (inst.opr1_sel)
            opr1_rs1:  operand1 = rs1_value;
            opr1_pc:   operand1 = inst.pc;
            opr1_zero: operand1 = '0;
            default:   operand1 = xlen_t'(inst.rs1);
        endcase
        case (inst.opr2_sel)
            opr2_rs2:  operand2 = rs2_value;
            opr2_imm:  operand2 = inst.imm;
            opr2_four: operand2 = xlen_t'(4);
            default:   operand2 = '0;
        endcase
    end

    // A register source only matters when it is actually selected
    assign ready = ((inst.opr1_sel != opr1_rs1) || rs1_ready) &&
                   ((inst.opr2_sel != opr2_rs2) || rs2_ready);

endmodule

// ==== waw_check.sv ====
module waw_check import issue_pkg::*; (
    input  dec_bundle_t inst,
    input  ex_track_t   ip0_ex,
    input  ex_track_t   ip1_ex,
    input  wb_fwd_t     ip0_wb,
    input  wb_fwd_t     ip1_wb,
    input  ex_track_t   lsp_ag,
    input  logic        lsp_mem_wb_en,
    input  reg_addr_t   lsp_mem_dst,
    output logic        ip_clear,
    output logic        lsp_clear
);

    logic lsp_writes_rd;
    logic ip_writes_rd;

    // Load/store results land late, an integer op must not overtake them
    assign lsp_writes_rd = ex_writes(lsp_ag, inst.rd) ||
                           (lsp_mem_wb_en && (lsp_mem_dst == inst.rd));

    // Held or accepted execute, or writeback, in either integer pipe
    assign ip_writes_rd = ex_writes(ip0_ex, inst.rd) || ex_writes(ip1_ex, inst.rd) ||
                          wb_writes(ip0_wb, inst.rd) || wb_writes(ip1_wb, inst.rd);

    assign ip_clear  = !inst.wb_en || !lsp_writes_rd;
    assign lsp_clear = !inst.wb_en || !ip_writes_rd;

endmodule

// ==== issue_arbiter.sv ====
module issue_arbiter import issue_pkg::*; (
    input  dec_bundle_t dec0,
    input  logic        dec0_valid,
    input  dec_bundle_t dec1,
    input  logic        dec1_valid,
    input  logic [1:0]  opr_ready,
    input  logic [1:0]  ip_clear,
    input  logic [1:0]  lsp_clear,
    input  logic        ip0_ready,
    input  logic        ip1_ready,
    input  logic        lsp_ready,
    input  logic        pipe_flush,
    output logic        issue_dec0,
    output logic        issue_dec1,
    output issue_sel_t  sel_ip0,
    output issue_sel_t  sel_ip1,
    output issue_sel_t  sel_lsp
);

    logic dec0_is_int;
    logic dec0_is_ls;
    logic dec1_is_int;
    logic dec1_is_ls;
    logic same_rd;
    logic raw_rs1;
    logic raw_rs2;
    logic pair_ok;

    assign dec0_is_int = (dec0.op_type == op_int);
    assign dec1_is_int = (dec1.op_type == op_int);
    assign dec0_is_ls  = (dec0.op_type == op_load) || (dec0.op_type == op_store);
    assign dec1_is_ls  = (dec1.op_type == op_load) || (dec1.op_type == op_store);

    // Slot 1 must neither write slot 0's rd nor read it
    assign same_rd = dec0.wb_en && dec1.wb_en && (dec0.rd == dec1.rd);
    assign raw_rs1 = dec0.wb_en && (dec1.opr1_sel == opr1_rs1) && (dec0.rd == dec1.rs1);
    assign raw_rs2 = dec0.wb_en && (dec1.opr2_sel == opr2_rs2) && (dec0.rd == dec1.rs2);
    assign pair_ok = dec0_valid && dec1_valid && !same_rd && !raw_rs1 && !raw_rs2;

    always_comb begin
        sel_ip0    = '0;
        sel_ip1    = '0;
        sel_lsp    = '0;
        issue_dec0 = 1'b0;
        issue_dec1 = 1'b0;

        if (!pipe_flush && dec0_valid && opr_ready[0]) begin
            // ip1 is preferred so that ip0 stays free for slot 1
            if (dec0_is_int && ip_clear[0]) begin
                if (ip1_ready) begin
                    sel_ip1.issue = 1'b1;
                end else if (ip0_ready) begin
                    sel_ip0.issue = 1'b1;
                end
            end else if (dec0_is_ls && lsp_clear[0] && lsp_ready) begin
                sel_lsp.issue = 1'b1;
            end
            issue_dec0 = sel_ip0.issue || sel_ip1.issue || sel_lsp.issue;

            if (issue_dec0 && pair_ok && opr_ready[1]) begin
                if (dec1_is_int && ip_clear[1]) begin
                    if (!sel_ip0.issue && ip0_ready) begin
                        sel_ip0 = '{issue: 1'b1, from_slot1: 1'b1};
                    end else if (!sel_ip1.issue && ip1_ready) begin
                        sel_ip1 = '{issue: 1'b1, from_slot1: 1'b1};
                    end
                end else if (dec1_is_ls && !dec0_is_ls && lsp_clear[1] && lsp_ready) begin
                    sel_lsp = '{issue: 1'b1, from_slot1: 1'b1};
                end
                issue_dec1 = sel_ip0.from_slot1 || sel_ip1.from_slot1 || sel_lsp.from_slot1;
            end
        end
    end

endmodule

// ==== fu_dispatch.sv ====
module fu_dispatch import issue_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        pipe_flush,
    input  dec_bundle_t dec0,
    input  dec_bundle_t dec1,
    input  xlen_t       dec0_opr1,
    input  xlen_t       dec0_opr2,
    input  xlen_t       dec1_opr1,
    input  xlen_t       dec1_opr2,
    input  issue_sel_t  sel_ip0,
    input  issue_sel_t  sel_ip1,
    input  issue_sel_t  sel_lsp,
    output ip_req_t     ip0_req,
    output logic        ip0_valid,
    input  logic        ip0_ready,
    output ip_req_t     ip1_req,
    output logic        ip1_valid,
    input  logic        ip1_ready,
    output lsp_req_t    lsp_req,
    output logic        lsp_valid,
    input  logic        lsp_ready,
    output ex_track_t   ip0_ex,
    output ex_track_t   ip1_ex,
    output ex_track_t   lsp_ag
);

    ip_req_t  slot_ip  [2];
    lsp_req_t slot_lsp [2];

    function automatic ip_req_t build_ip(dec_bundle_t d, xlen_t opr1, xlen_t opr2);
        ip_req_t r;
        r.pc       = d.pc;
        r.dst      = d.rd;
        r.wb_en    = d.wb_en;
        r.op       = d.op;
        r.option   = d.option;
        r.truncate = d.truncate;
        r.operand1 = opr1;
        r.operand2 = opr2;
        return r;
    endfunction

    // Address is base plus offset, source is the store data
    function automatic lsp_req_t build_lsp(dec_bundle_t d, xlen_t opr1, xlen_t opr2);
        lsp_req_t r;
        r.pc        = d.pc;
        r.dst       = d.rd;
        r.wb_en     = d.wb_en;
        r.base      = opr1;
        r.offset    = d.imm[lsp_offset_w-1:0];
        r.source    = opr2;
        r.mem_sign  = d.mem_sign;
        r.mem_width = d.mem_width;
        return r;
    endfunction

    // New issue sets valid, a taken request or a flush drops it, else hold
    function automatic logic next_valid(logic issue, logic valid, logic ready, logic flush);
        if (issue) begin
            return 1'b1;
        end
        return valid && !ready && !flush;
    endfunction

    assign slot_ip[0]  = build_ip(dec0, dec0_opr1, dec0_opr2);
    assign slot_ip[1]  = build_ip(dec1, dec1_opr1, dec1_opr2);
    assign slot_lsp[0] = build_lsp(dec0, dec0_opr1, dec0_opr2);
    assign slot_lsp[1] = build_lsp(dec1, dec1_opr1, dec1_opr2);

    always_ff @(posedge clk) begin
        if (rst) begin
            ip0_valid <= 1'b0;
            ip1_valid <= 1'b0;
            lsp_valid <= 1'b0;
        end else begin
            ip0_valid <= next_valid(sel_ip0.issue, ip0_valid, ip0_ready, pipe_flush);
            ip1_valid <= next_valid(sel_ip1.issue, ip1_valid, ip1_ready, pipe_flush);
            lsp_valid <= next_valid(sel_lsp.issue, lsp_valid, lsp_ready, pipe_flush);
        end
    end

    // Payload only moves on issue, so a stalled request keeps its fields
    always_ff @(posedge clk) begin
        if (sel_ip0.issue) begin
            ip0_req <= slot_ip[sel_ip0.from_slot1];
        end
        if (sel_ip1.issue) begin
            ip1_req <= slot_ip[sel_ip1.from_slot1];
        end
        if (sel_lsp.issue) begin
            lsp_req <= slot_lsp[sel_lsp.from_slot1];
        end
    end

    assign ip0_ex = '{valid: ip0_valid, ready: ip0_ready, wb_en: ip0_req.wb_en,
                      dst: ip0_req.dst};
    assign ip1_ex = '{valid: ip1_valid, ready: ip1_ready, wb_en: ip1_req.wb_en,
                      dst: ip1_req.dst};
    assign lsp_ag = '{valid: lsp_valid, ready: lsp_ready, wb_en: lsp_req.wb_en,
                      dst: lsp_req.dst};

endmodule

// ==== issue_stage.sv ====
module issue_stage import issue_pkg::*; (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             pipe_flush,
    // Decode side
    input  dec_bundle_t                      dec0,
    input  logic                             dec0_valid,
    output logic                             dec0_ready,
    input  dec_bundle_t                      dec1,
    input  logic                             dec1_valid,
    output logic                             dec1_ready,
    // Register file, slot 0 rs1/rs2 then slot 1 rs1/rs2
    output reg_addr_t [num_read_ports-1:0]   rf_rsrc,
    input  xlen_t     [num_read_ports-1:0]   rf_rdata,
    // Integer pipes
    output ip_req_t                          ip0_req,
    output logic                             ip0_valid,
    input  logic                             ip0_ready,
    output ip_req_t                          ip1_req,
    output logic                             ip1_valid,
    input  logic                             ip1_ready,
    input  xlen_t                            ip0_fwd,
    input  xlen_t                            ip1_fwd,
    input  wb_fwd_t                          ip0_wb,
    input  wb_fwd_t                          ip1_wb,
    // Load/store pipe
    output lsp_req_t                         lsp_req,
    output logic                             lsp_valid,
    input  logic                             lsp_ready,
    input  wb_fwd_t                          lsp_wb,
    input  logic                             lsp_mem_busy,
    input  logic                             lsp_mem_wb_en,
    input  reg_addr_t                        lsp_mem_dst
);

    dec_bundle_t dec [2];
    xlen_t       opr1 [2];
    xlen_t       opr2 [2];
    logic [1:0]  opr_ready;
    logic [1:0]  ip_clear;
    logic [1:0]  lsp_clear;
    ex_track_t   ip0_ex;
    ex_track_t   ip1_ex;
    ex_track_t   lsp_ag;
    issue_sel_t  sel_ip0;
    issue_sel_t  sel_ip1;
    issue_sel_t  sel_lsp;
    logic        issue_dec0;
    logic        issue_dec1;

    assign dec[0] = dec0;
    assign dec[1] = dec1;

    for (genvar i = 0; i < 2; i++) begin : g_slot
        assign rf_rsrc[2*i]   = dec[i].rs1;
        assign rf_rsrc[2*i+1] = dec[i].rs2;

        operand_select i_operand_select (
            .inst(dec[i]), .rs1_data(rf_rdata[2*i]), .rs2_data(rf_rdata[2*i+1]),
            .ip0_ex(ip0_ex), .ip1_ex(ip1_ex), .lsp_ag(lsp_ag),
            .ip0_fwd(ip0_fwd), .ip1_fwd(ip1_fwd),
            .ip0_wb(ip0_wb), .ip1_wb(ip1_wb), .lsp_wb(lsp_wb),
            .lsp_mem_wb_en(lsp_mem_wb_en), .lsp_mem_dst(lsp_mem_dst),
            .operand1(opr1[i]), .operand2(opr2[i]), .ready(opr_ready[i])
        );

        waw_check i_waw_check (
            .inst(dec[i]), .ip0_ex(ip0_ex), .ip1_ex(ip1_ex),
            .ip0_wb(ip0_wb), .ip1_wb(ip1_wb), .lsp_ag(lsp_ag),
            .lsp_mem_wb_en(lsp_mem_wb_en), .lsp_mem_dst(lsp_mem_dst),
            .ip_clear(ip_clear[i]), .lsp_clear(lsp_clear[i])
        );
    end

    issue_arbiter i_issue_arbiter (
        .dec0(dec0), .dec0_valid(dec0_valid), .dec1(dec1), .dec1_valid(dec1_valid),
        .opr_ready(opr_ready), .ip_clear(ip_clear), .lsp_clear(lsp_clear),
        .ip0_ready(ip0_ready), .ip1_ready(ip1_ready), .lsp_ready(lsp_ready),
        .pipe_flush(pipe_flush), .issue_dec0(issue_dec0), .issue_dec1(issue_dec1),
        .sel_ip0(sel_ip0), .sel_ip1(sel_ip1), .sel_lsp(sel_lsp)
    );

    fu_dispatch i_fu_dispatch (
        .clk(clk), .rst(rst), .pipe_flush(pipe_flush),
        .dec0(dec0), .dec1(dec1),
        .dec0_opr1(opr1[0]), .dec0_opr2(opr2[0]),
        .dec1_opr1(opr1[1]), .dec1_opr2(opr2[1]),
        .sel_ip0(sel_ip0), .sel_ip1(sel_ip1), .sel_lsp(sel_lsp),
        .ip0_req(ip0_req), .ip0_valid(ip0_valid), .ip0_ready(ip0_ready),
        .ip1_req(ip1_req), .ip1_valid(ip1_valid), .ip1_ready(ip1_ready),
        .lsp_req(lsp_req), .lsp_valid(lsp_valid), .lsp_ready(lsp_ready),
        .ip0_ex(ip0_ex), .ip1_ex(ip1_ex), .lsp_ag(lsp_ag)
    );

    // Slot 0 stalls decode when it cannot go and no flush discards it
    assign dec0_ready = !rst && !(dec0_valid && !issue_dec0 && !pipe_flush);
    assign dec1_ready = dec0_ready && issue_dec1;

    // lsp_mem_busy stays unused since this stage has no load/store barrier

endmodule

// ==== tb_issue_stage.sv ====
module tb_issue_stage import issue_pkg::*; ;

    localparam int words_per_line = 15;
    localparam int max_lines      = 64;
    localparam int reset_cycles   = 8;

    logic        clk = 1'b0;
    logic        rst;
    logic        pipe_flush;
    dec_bundle_t dec0;
    logic        dec0_valid;
    logic        dec0_ready;
    dec_bundle_t dec1;
    logic        dec1_valid;
    logic        dec1_ready;
    reg_addr_t [num_read_ports-1:0] rf_rsrc;
    xlen_t     [num_read_ports-1:0] rf_rdata;
    ip_req_t     ip0_req;
    logic        ip0_valid;
    logic        ip0_ready;
    ip_req_t     ip1_req;
    logic        ip1_valid;
    logic        ip1_ready;
    xlen_t       ip0_fwd;
    xlen_t       ip1_fwd;
    wb_fwd_t     ip0_wb;
    wb_fwd_t     ip1_wb;
    lsp_req_t    lsp_req;
    logic        lsp_valid;
    logic        lsp_ready;
    wb_fwd_t     lsp_wb;
    logic        lsp_mem_busy;
    logic        lsp_mem_wb_en;
    reg_addr_t   lsp_mem_dst;

    logic [63:0] stim [words_per_line*max_lines];
    int          num_lines = 0;
    int          errors = 0;
    int          cycle = 0;
    int          limit = 0;

    issue_stage i_issue_stage (.*);

    always #2 clk = ~clk;

    // Register file model where each register holds 0xa0 plus its index
    always_comb begin
        for (int i = 0; i < num_read_ports; i++) begin
            rf_rdata[i] = 64'ha0 + xlen_t'(rf_rsrc[i]);
        end
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (limit > 0 && cycle >= limit) begin
            $display("Timeout: run did not end within %0d cycles", limit);
            $display("Checks failed");
            $finish;
        end
    end

    // Decode word fields are pc, type, opr1_sel, opr2_sel, wb_en, rs1, rs2 and rd
    // The immediate is pc plus 0x100
    function automatic dec_bundle_t unpack_dec(logic [63:0] w);
        dec_bundle_t d;
        d          = '0;
        d.pc       = xlen_t'(w[47:40]);
        d.imm      = xlen_t'(w[47:40]) + 64'h100;
        d.op_type  = op_type_e'(w[38:36]);
        d.opr1_sel = opr1_sel_e'(w[33:32]);
        d.opr2_sel = opr2_sel_e'(w[29:28]);
        d.wb_en    = w[24];
        d.rs1      = w[20:16];
        d.rs2      = w[12:8];
        d.rd       = w[4:0];
        return d;
    endfunction

    function automatic wb_fwd_t unpack_wb(logic [63:0] w);
        wb_fwd_t r;
        r.valid  = w[28];
        r.wb_en  = w[24];
        r.dst    = w[20:16];
        r.result = xlen_t'(w[15:0]);
        return r;
    endfunction

    task automatic compare(input string name, input logic [63:0] expected,
                           input logic [63:0] actual);
        if (actual !== expected) begin
            errors++;
            $display("ERROR %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic apply_line(input int k);
        int base;
        base          = k * words_per_line;
        pipe_flush    = stim[base][20];
        dec0_valid    = stim[base][16];
        dec1_valid    = stim[base][12];
        ip0_ready     = stim[base][8];
        ip1_ready     = stim[base][4];
        lsp_ready     = stim[base][0];
        dec0          = unpack_dec(stim[base+1]);
        dec1          = unpack_dec(stim[base+2]);
        ip0_fwd       = xlen_t'(stim[base+3][7:0]);
        ip1_fwd       = xlen_t'(stim[base+3][15:8]);
        ip0_wb        = unpack_wb(stim[base+4]);
        ip1_wb        = unpack_wb(stim[base+5]);
        lsp_wb        = unpack_wb(stim[base+6]);
        lsp_mem_busy  = stim[base+7][12];
        lsp_mem_wb_en = stim[base+7][8];
        lsp_mem_dst   = stim[base+7][4:0];
    endtask

    // Decode ready and the read port addresses are combinational
    // They are sampled before the rising edge
    task automatic check_ready(input int k);
        int          base;
        logic [63:0] exp;
        base = k * words_per_line;
        exp  = stim[base+8];
        if (stim[base+14][0]) begin
            compare($sformatf("line %0d dec0_ready", k + 1), 64'(exp[16]), 64'(dec0_ready));
            compare($sformatf("line %0d dec1_ready", k + 1), 64'(exp[12]), 64'(dec1_ready));
        end
        // Read ports go slot 0 rs1, slot 0 rs2, slot 1 rs1, slot 1 rs2
        compare($sformatf("line %0d rf_rsrc[0]", k + 1),
                64'(stim[base+1][20:16]), 64'(rf_rsrc[0]));
        compare($sformatf("line %0d rf_rsrc[1]", k + 1),
                64'(stim[base+1][12:8]), 64'(rf_rsrc[1]));
        compare($sformatf("line %0d rf_rsrc[2]", k + 1),
                64'(stim[base+2][20:16]), 64'(rf_rsrc[2]));
        compare($sformatf("line %0d rf_rsrc[3]", k + 1),
                64'(stim[base+2][12:8]), 64'(rf_rsrc[3]));
    endtask

    task automatic check_outputs(input int k);
        int          base;
        logic [63:0] exp;
        logic [63:0] mask;
        base = k * words_per_line;
        exp  = stim[base+8];
        mask = stim[base+14];
        if (mask[1]) begin
            compare($sformatf("line %0d ip0_valid", k + 1), 64'(exp[8]), 64'(ip0_valid));
            compare($sformatf("line %0d ip1_valid", k + 1), 64'(exp[4]), 64'(ip1_valid));
            compare($sformatf("line %0d lsp_valid", k + 1), 64'(exp[0]), 64'(lsp_valid));
        end
        if (mask[2]) begin
            compare($sformatf("line %0d ip0 operand1", k + 1), stim[base+9], ip0_req.operand1);
            compare($sformatf("line %0d ip0 operand2", k + 1), stim[base+10], ip0_req.operand2);
        end
        if (mask[3]) begin
            compare($sformatf("line %0d ip1 operand1", k + 1), stim[base+11], ip1_req.operand1);
            compare($sformatf("line %0d ip1 operand2", k + 1), stim[base+12], ip1_req.operand2);
        end
        if (mask[4]) begin
            compare($sformatf("line %0d lsp base", k + 1), stim[base+13], lsp_req.base);
        end
    endtask

    initial begin
        rst           = 1'b1;
        pipe_flush    = 1'b0;
        dec0          = unpack_dec(64'h100001010203);
        dec0_valid    = 1'b1;
        dec1          = '0;
        dec1_valid    = 1'b0;
        ip0_ready     = 1'b1;
        ip1_ready     = 1'b1;
        lsp_ready     = 1'b1;
        ip0_fwd       = '0;
        ip1_fwd       = '0;
        ip0_wb        = '0;
        ip1_wb        = '0;
        lsp_wb        = '0;
        lsp_mem_busy  = 1'b0;
        lsp_mem_wb_en = 1'b0;
        lsp_mem_dst   = '0;

        $readmemh("issue_stim.txt", stim);
        // Every line checks something, so an empty or unread mask word ends the stimulus
        while (num_lines < max_lines &&
               !$isunknown(stim[num_lines*words_per_line+14]) &&
               stim[num_lines*words_per_line+14] != '0) begin
            num_lines++;
        end
        if (num_lines == 0) begin
            errors++;
            $display("No stimulus lines could be read from issue_stim.txt");
        end
        limit = num_lines + reset_cycles + 20;

        // Slot 0 is valid during reset but must not be accepted
        repeat (reset_cycles) begin
            @(negedge clk);
            compare("reset dec0_ready", 64'd0, 64'(dec0_ready));
            compare("reset ip0_valid", 64'd0, 64'(ip0_valid));
            compare("reset ip1_valid", 64'd0, 64'(ip1_valid));
            compare("reset lsp_valid", 64'd0, 64'(lsp_valid));
        end
        rst = 1'b0;

        for (int k = 0; k < num_lines; k++) begin
            apply_line(k);
            #1;
            check_ready(k);
            @(negedge clk);
            check_outputs(k);
        end

        $display("Errors: %0d over %0d stimulus lines", errors, num_lines);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// ==== issue_stage.f ====
issue_pkg.sv
operand_bypass.sv
operand_select.sv
waw_check.sv
issue_arbiter.sv
fu_dispatch.sv
issue_stage.sv
tb_issue_stage.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the issue stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_issue_stage -f issue_stage.f -o sim_issue_stage
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_issue_stage > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Checks failed" sim.log; then
    exit 1
fi
exit 0

// ==== issue_stim.txt ====
// ctrl(flush d0v d1v ip0r ip1r lspr) dec0 dec1 fwd(ip1 ip0) ip0_wb ip1_wb lsp_wb mem(busy wb dst)
// exp(d0r d1r v0 v1 vl) ip0_op1 ip0_op2 ip1_op1 ip1_op2 lsp_base mask
001111 000000000000 000000000000 e1e0 00000000 00000000 00000000 0000 10000 0 0 0 0 0 03
011111 100001010203 200111040506 e1e0 00000000 00000000 00000000 0000 11110 20 120 a1 a2 0 0f
010111 300021060007 000000000000 e1e0 00000000 11060777 00000000 0000 10010 0 0 e0 4 0 0b
010101 400011080009 000000000000 e1e0 00000000 00000000 00000000 0000 10110 a8 140 e0 4 0 0f
010011 50001109000a 000000000000 e1e0 00000000 00000000 00000000 0000 00100 a8 140 0 0 0 07
010111 50001109000a 000000000000 e1e0 00000000 00000000 00000000 0000 10010 0 0 e0 150 0 0b
011111 700001000b0c 7400010c000d e1e0 11000555 00000000 00000000 0000 10010 0 0 0 ab 0 0b
011111 80201101000e 84201102000f e1e0 00000000 00000000 00000000 0000 10001 0 0 0 0 a1 13
010111 900011050010 000000000000 e1e0 00000000 00000000 00000000 0105 00000 0 0 0 0 0 03
010111 a00121000011 000000000000 e1e0 00000000 00000000 00000000 0111 00000 0 0 0 0 0 03
010111 a00121000011 000000000000 e1e0 00000000 00000000 00000000 0000 10010 0 0 a0 4 0 0b
010111 b02011010012 000000000000 e1e0 00000000 11120999 00000000 0000 00000 0 0 0 0 0 03
010111 c00321070013 000000000000 e1e0 00000000 00000000 00000000 0000 10010 0 0 7 4 0 0b
110101 c00321070013 000000000000 e1e0 00000000 00000000 00000000 0000 10000 0 0 0 0 0 03
001111 000000000000 000000000000 e1e0 00000000 00000000 00000000 0000 10000 0 0 0 0 0 03
